// File: Makefile
# Verilator build and run of the sine testbench.

VERILATOR ?= verilator
TOP       ?= sineTheta2Tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# a $fatal in the run gives a non-zero exit status.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+src
src/scaraPkg.sv
src/sineControl.sv
src/fpSquare.sv
src/oneMinus.sv
src/fpSqrt.sv
src/sineTheta2.sv
tb/sineTheta2Tb.sv

// File: src/fpSqrt.sv
/*
  Iterative double square root.
  Evens out the exponent, then one root bit per
  cycle by restoring digit recurrence, packed truncated.
*/
`default_nettype none

`include "sine_defs.svh"

module fpSqrt (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  scaraPkg::fpDouble radicand,
  output logic              ack,
  output scaraPkg::fpDouble root
);
  import scaraPkg::*;

  localparam int mantWidth = `FP_MANT_WIDTH;
  localparam int remWidth  = mantWidth + 4;
  localparam int radWidth  = 2 * (mantWidth + 1);

  logic                     busy;
  logic                     start;
  logic                     isZero;
  logic [5:0]               count;
  logic [radWidth-1:0]      radReg;   // two bits consumed per cycle.
  logic [remWidth-1:0]      rem;
  logic [remWidth-1:0]      remShift;
  logic [remWidth-1:0]      trial;
  logic [mantWidth:0]       q;
  fpMantissa                mant;
  fpExponent                rootExp;
  logic [`FP_EXP_WIDTH:0]   expSum;

  assign start    = req && !ack && !busy;
  assign mant     = {1'b1, radicand.fraction};
  // (e + bias - 1 + odd) / 2 gives the halved biased exponent.
  assign expSum   = {1'b0, radicand.exponent} + 12'(`FP_BIAS - 1) + 12'(radicand.exponent[0]);
  assign remShift = {rem[remWidth-3:0], radReg[radWidth-1 -: 2]};
  assign trial    = {1'b0, q, 2'b01};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      ack   <= 1'b0;
      count <= '0;
    end else begin
      if (ack && !req) ack <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        if (count == 6'(mantWidth + 1)) begin   // pack cycle.
          busy <= 1'b0;
          ack  <= 1'b1;
        end else count <= count + 6'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      // even unbiased exponent keeps the significand, odd doubles it.
      radReg  <= radicand.exponent[0] ? {1'b0, mant, {(mantWidth+1){1'b0}}}
                                      : {mant, {(mantWidth+2){1'b0}}};
      rootExp <= expSum[`FP_EXP_WIDTH:1];
      isZero  <= (radicand.exponent == '0);
      rem     <= '0;
      q       <= '0;
    end else if (busy && count < 6'(mantWidth + 1)) begin
      radReg <= radReg << 2;
      if (remShift >= trial) begin
        rem <= remShift - trial;
        q   <= {q[mantWidth-1:0], 1'b1};
      end else begin
        rem <= remShift;
        q   <= {q[mantWidth-1:0], 1'b0};
      end
    end else if (busy) begin
      root <= isZero ? '0 : {1'b0, rootExp, q[mantWidth-1:1]};   // top bit is the hidden one.
    end
  end

  reqOrder: assert property (@(posedge clk) disable iff (reset) $fell(req) |-> ack)
    else $error("fpSqrt req dropped before ack");

endmodule

`default_nettype wire

// File: src/fpSquare.sv
/*
  Iterative double squarer.
  One shift-add per cycle over the 53-bit significand,
  then a single normalize and pack cycle, truncated.
*/
`default_nettype none

`include "sine_defs.svh"

module fpSquare (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  scaraPkg::fpDouble operand,
  output logic              ack,
  output scaraPkg::fpDouble product
);
  import scaraPkg::*;

  localparam int mantWidth = `FP_MANT_WIDTH;
  localparam int fracWidth = `FP_FRAC_WIDTH;

  logic                          busy;
  logic                          start;
  logic [5:0]                    count;
  fpMantissa                     mcand;
  fpMantissa                     mplier;
  logic [2*mantWidth-1:0]        acc;
  logic [mantWidth:0]            partial;
  fpExponent                     expIn;
  logic                          isZero;
  logic                          normShift;
  logic signed [`FP_EXP_WIDTH+1:0] expOut;

  assign start     = req && !ack && !busy;
  assign partial   = {1'b0, acc[2*mantWidth-1:mantWidth]} + {1'b0, (mplier[0] ? mcand : '0)};
  assign normShift = acc[2*mantWidth-1];   // product in [2, 4).
  assign expOut    = $signed({1'b0, expIn, 1'b0}) - 13'(`FP_BIAS) + 13'(normShift);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      ack   <= 1'b0;
      count <= '0;
    end else begin
      if (ack && !req) ack <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        if (count == 6'(mantWidth)) begin   // normalize cycle done.
          busy <= 1'b0;
          ack  <= 1'b1;
        end else count <= count + 6'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= {1'b1, operand.fraction};
      mplier <= {1'b1, operand.fraction};
      acc    <= '0;
      expIn  <= operand.exponent;
      isZero <= (operand.exponent == '0);   // denormals flush too.
    end else if (busy && count < 6'(mantWidth)) begin
      acc    <= {partial, acc[mantWidth-1:1]};
      mplier <= mplier >> 1;
    end else if (busy) begin
      product.sign <= 1'b0;                 // a square is never negative.
      if (isZero || expOut <= 0) begin
        product.exponent <= '0;
        product.fraction <= '0;
      end else begin
        product.exponent <= expOut[`FP_EXP_WIDTH-1:0];
        product.fraction <= normShift ? acc[2*mantWidth-2 -: fracWidth]
                                      : acc[2*mantWidth-3 -: fracWidth];
      end
    end
  end

  reqOrder: assert property (@(posedge clk) disable iff (reset) $fell(req) |-> ack)
    else $error("fpSquare req dropped before ack");

endmodule

`default_nettype wire

// File: src/oneMinus.sv
/*
  One minus a double in [0, 1].
  Aligns the operand to the exponent of 1.0, subtracts,
  then normalizes left by one place per cycle.
*/
`default_nettype none

`include "sine_defs.svh"

module oneMinus (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  scaraPkg::fpDouble operand,
  output logic              ack,
  output scaraPkg::fpDouble difference
);
  import scaraPkg::*;

  localparam int mantWidth = `FP_MANT_WIDTH;

  logic               busy;
  logic               start;
  logic               done;
  logic [mantWidth:0] diff;       // 1.0 sits at the top bit.
  fpExponent          expOut;
  fpExponent          shiftAmt;
  fpMantissa          mant;

  assign start    = req && !ack && !busy;
  assign mant     = (operand.exponent == '0) ? '0 : {1'b1, operand.fraction};
  assign shiftAmt = fpExponent'(`FP_BIAS) - operand.exponent;
  assign done     = (diff == '0) || diff[mantWidth];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      ack  <= 1'b0;
    end else begin
      if (ack && !req) ack <= 1'b0;
      if (start) busy <= 1'b1;
      else if (busy && done) begin
        busy <= 1'b0;
        ack  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      diff   <= {1'b1, {mantWidth{1'b0}}} - ({mant, 1'b0} >> shiftAmt);
      expOut <= fpExponent'(`FP_BIAS);
    end else if (busy) begin
      if (diff == '0) difference <= '0;  // operand was exactly one.
      else if (diff[mantWidth]) difference <= {1'b0, expOut, diff[mantWidth-1:1]};
      else begin
        diff   <= diff << 1;
        expOut <= expOut - 1'b1;
      end
    end
  end

  // the operand is a square, so it arrives positive.
  posOperand: assert property (@(posedge clk) disable iff (reset)
    start |-> !operand.sign)
    else $error("oneMinus operand is negative");

endmodule

`default_nettype wire

// File: src/scaraPkg.sv
/*
  Shared types for the SCARA sine datapath:
  width typedefs, the double as a packed struct,
  and the control state enum.
*/
`default_nettype none

`include "sine_defs.svh"

package scaraPkg;

  typedef logic [`FP_EXP_WIDTH-1:0] fpExponent;   // biased.
  typedef logic [`FP_FRAC_WIDTH-1:0] fpFraction;
  typedef logic [`FP_MANT_WIDTH-1:0] fpMantissa;  // hidden one at the top.

  // one double as it travels on every data port.
  typedef struct packed {
    logic      sign;
    fpExponent exponent;
    fpFraction fraction;
  } fpDouble;

  // controller sequence, one state per unit handshake.
  typedef enum logic [2:0] {
    idle,
    square,
    subtract,
    root,
    finish
  } sineState;

endpackage

`default_nettype wire

// File: src/sineControl.sv
/*
  Sequencing FSM for the sine of theta2.
  Runs the outer four-phase handshake and the
  square, one-minus and root unit handshakes in turn.
*/
`default_nettype none

`include "sine_defs.svh"

module sineControl (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  scaraPkg::fpDouble cosTh2,
  output logic              ack,
  output logic              mulReq,
  input  logic              mulAck,
  output logic              subReq,
  input  logic              subAck,
  output logic              sqrtReq,
  input  logic              sqrtAck,
  input  scaraPkg::fpDouble root,
  output scaraPkg::fpDouble sinTh2
);
  import scaraPkg::*;

  sineState state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      ack     <= 1'b0;
      mulReq  <= 1'b0;
      subReq  <= 1'b0;
      sqrtReq <= 1'b0;
    end else begin
      case (state)
        idle: if (req) begin
          mulReq <= 1'b1;
          state  <= square;
        end
        square: begin
          if (mulAck) mulReq <= 1'b0;   // release the multiplier.
          else if (!mulReq) begin       // ack back low, product is stable.
            subReq <= 1'b1;
            state  <= subtract;
          end
        end
        subtract: begin
          if (subAck) subReq <= 1'b0;
          else if (!subReq) begin
            sqrtReq <= 1'b1;
            state   <= scaraPkg::root;  // port name hides the literal.
          end
        end
        scaraPkg::root: begin
          if (sqrtAck) sqrtReq <= 1'b0;
          else if (!sqrtReq) begin
            ack   <= 1'b1;              // sinTh2 already latched.
            state <= finish;
          end
        end
        finish: if (!req) begin
          ack   <= 1'b0;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // result register, loaded while the root unit acks.
  always_ff @(posedge clk) begin
    if (state == scaraPkg::root && sqrtAck) sinTh2 <= root;
  end

  // the cosine must stay within [-1, 1] for the whole request.
  cosRange: assert property (@(posedge clk) disable iff (reset)
    req |-> (cosTh2.exponent < 11'(`FP_BIAS)) ||
            (cosTh2.exponent == 11'(`FP_BIAS) && cosTh2.fraction == '0))
    else $error("cosTh2 outside [-1, 1]");

  oneUnit: assert property (@(posedge clk) disable iff (reset)
    $onehot0({mulReq, subReq, sqrtReq}))
    else $error("more than one unit request active");

endmodule

`default_nettype wire

// File: src/sineTheta2.sv
/*
  Top level for sin theta2 = sqrt(1 - cos^2 theta2).
  Controller plus squarer, one-minus and root units.
*/
`default_nettype none

module sineTheta2 (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  scaraPkg::fpDouble cosTh2,
  output logic              ack,
  output scaraPkg::fpDouble sinTh2
);
  import scaraPkg::*;

  logic    mulReq, mulAck;
  logic    subReq, subAck;
  logic    sqrtReq, sqrtAck;
  fpDouble cosSquared;
  fpDouble oneMinusSq;
  fpDouble root;

  sineControl control (
    .clk(clk), .reset(reset),
    .req(req), .cosTh2(cosTh2), .ack(ack),
    .mulReq(mulReq), .mulAck(mulAck),
    .subReq(subReq), .subAck(subAck),
    .sqrtReq(sqrtReq), .sqrtAck(sqrtAck),
    .root(root), .sinTh2(sinTh2)
  );

  fpSquare squarer (
    .clk(clk), .reset(reset), .req(mulReq), .operand(cosTh2),
    .ack(mulAck), .product(cosSquared)
  );

  oneMinus subtractor (
    .clk(clk), .reset(reset), .req(subReq), .operand(cosSquared),
    .ack(subAck), .difference(oneMinusSq)
  );

  fpSqrt rooter (
    .clk(clk), .reset(reset), .req(sqrtReq), .radicand(oneMinusSq),
    .ack(sqrtAck), .root(root)
  );

endmodule

`default_nettype wire

// File: src/sine_defs.svh
/*
  Format macros for the IEEE-754 double
  used by the sine datapath units.
*/
`ifndef SINE_DEFS_SVH
`define SINE_DEFS_SVH

// biased exponent width.
`define FP_EXP_WIDTH 11

`define FP_FRAC_WIDTH 52   // stored fraction, hidden one not included.

`define FP_BIAS 1023

// significand with the hidden one.
`define FP_MANT_WIDTH 53

`endif

// File: tb/sineTheta2Tb.sv
/*
  Self-checking testbench for the sine of theta2.
  Table of cosines with tolerance classes, applied in a loop
  over the four-phase handshake, plus a handshake monitor and a watchdog.
*/
`default_nettype none

module sineTheta2Tb;
  import scaraPkg::*;

  typedef enum bit {exactTol, relTol} tolClass;

  localparam int  numCases     = 24;
  localparam int  firstRandom  = 8;       // rows below this are fixed.
  localparam int  driveDelay   = 10;
  localparam int  settleCycles = 200;     // longer than one full computation.
  localparam real maxMag       = 1.0 - 9.5367431640625e-07;   // 1 - 2^-20.
  localparam real relLimit     = 9.313225746154785e-10;       // 2^-30.

  logic    clk;
  logic    reset;
  logic    req;
  fpDouble cosTh2;
  logic    ack;
  fpDouble sinTh2;

  real     cosValue [numCases];
  tolClass tolKind [numCases];
  bit      abortMid [numCases];
  logic [15:0] lfsrState;
  logic    prevAck;
  logic    prevReq;
  fpDouble prevSin;

  sineTheta2 DUT (
    .clk(clk), .reset(reset), .req(req), .cosTh2(cosTh2),
    .ack(ack), .sinTh2(sinTh2)
  );

  always #50 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < count; k++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};   // one step per bit.
    end
    return value;
  endfunction

  function automatic void setRow(input int idx, input real c, input tolClass kind);
    cosValue[idx] = c;
    tolKind[idx]  = kind;
    abortMid[idx] = 1'b0;
  endfunction

  function automatic void buildTable();
    real mag;
    setRow(0, 0.0, exactTol);
    setRow(1, -0.0, exactTol);
    setRow(2, 1.0, exactTol);
    setRow(3, -1.0, exactTol);
    setRow(4, 0.5, relTol);
    setRow(5, maxMag, relTol);
    setRow(6, -maxMag, relTol);
    setRow(7, 0.6, relTol);
    abortMid[7] = 1'b1;                      // reset hits this one first.
    // random pairs of opposite sign.
    for (int i = firstRandom; i < numCases; i += 2) begin
      mag = $itor(randomBits(30)) / 1073741824.0 * maxMag;
      if (randomBits(1) != 0) mag = -mag;
      setRow(i, mag, relTol);
      setRow(i + 1, -mag, relTol);
    end
  endfunction

  task automatic driveAfterEdge();
    @(posedge clk);
    #driveDelay;
  endtask

  // starts and ends just after a rising edge.
  task automatic runRequest(input real c, output logic [63:0] result);
    int hold;
    cosTh2 = $realtobits(c);
    req    = 1'b1;
    do @(negedge clk); while (!ack);
    result = sinTh2;
    hold = int'(randomBits(3));
    repeat (hold) @(negedge clk);            // monitor watches sinTh2 here.
    driveAfterEdge();
    req = 1'b0;
    do driveAfterEdge(); while (ack);
  endtask

  task automatic resetMidway(input real c);
    cosTh2 = $realtobits(c);
    req    = 1'b1;
    repeat (40) @(posedge clk);
    #driveDelay;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #driveDelay;
    req   = 1'b0;
    reset = 1'b0;
    // nothing of the aborted run may come back.
    repeat (settleCycles) begin
      driveAfterEdge();
      assert (!ack) else abortRun("ack is high after a reset in mid computation");
    end
  endtask

  // outer handshake order, sampled away from the active edge.
  // req from the last negedge is what the DUT saw at the edge between.
  always @(negedge clk) begin
    if (!reset) begin
      if (ack && !prevAck)
        assert (prevReq) else abortRun("ack rose while req was low");
      if (ack && prevAck)
        assert (sinTh2 == prevSin) else abortRun($sformatf(
          "Error: time %0t sinTh2 expected %h got %h", $time, prevSin, sinTh2));
      if (!ack && prevAck)
        assert (!prevReq) else abortRun("ack fell while req was still high");
    end
    prevAck = ack;
    prevReq = req;
    prevSin = sinTh2;
  end

  initial begin
    repeat (numCases * 250 + 8) @(posedge clk);
    abortRun("watchdog expired, the DUT stopped answering requests");
  end

  initial begin
    logic [63:0] result;
    logic [63:0] prevResult;
    real want;
    real got;
    real err;
    clk       = 1'b0;
    reset     = 1'b1;
    req       = 1'b0;
    cosTh2    = '0;
    lfsrState = 16'd16;
    prevResult = '0;
    buildTable();
    repeat (8) @(posedge clk);
    #driveDelay;
    reset = 1'b0;
    driveAfterEdge();
    assert (!ack) else abortRun("ack is high after reset");

    for (int i = 0; i < numCases; i++) begin
      if (abortMid[i]) resetMidway(cosValue[i]);
      runRequest(cosValue[i], result);
      want = $sqrt(1.0 - cosValue[i] * cosValue[i]);
      got  = $bitstoreal(result);
      assert (result[63] == 1'b0) else abortRun($sformatf(
        "Error: time %0t sinTh2 sign expected 0 got 1", $time));
      if (tolKind[i] == exactTol) begin
        assert (result == $realtobits(want)) else abortRun($sformatf(
          "Error: time %0t sinTh2 expected %h got %h", $time, $realtobits(want), result));
      end else begin
        err = got - want;
        if (err < 0.0) err = -err;
        assert (err <= want * relLimit) else abortRun($sformatf(
          "Error: time %0t sinTh2 expected %.17g got %.17g", $time, want, got));
      end
      // opposite signs must square to the same bits.
      if (i > 0 && cosValue[i] == -cosValue[i-1])
        assert (result == prevResult) else abortRun($sformatf(
          "Error: time %0t sinTh2 expected %h got %h", $time, prevResult, result));
      prevResult = result;
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
